// File: alu_config.svh
// Queue depths, tag width and data width of the ALU execution unit
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Decode input queue entries, also the upstream credits after reset
`define ALU_QUEUE_DEPTH  4

// Result buffer entries
`define ALU_RESULT_DEPTH 4

// Operation tag carried through to the result
`define ALU_TAG_W        4

// Operand and result word
`define ALU_DATA_W       32

`endif

// File: alu_pkg.sv
// Opcode and path enums, operand word union and result flag type
`default_nettype none

package alu_pkg;

    // 00xx arithmetic, 01xx logic, 1x.. special (bit 2 ignored)
    typedef enum logic [3:0] {
        op_add  = 4'b0000,
        op_sub  = 4'b0001,
        op_mul  = 4'b0010,
        op_div  = 4'b0011,
        op_not  = 4'b0100,
        op_and  = 4'b0101,
        op_or   = 4'b0110,
        op_xor  = 4'b0111,
        op_wrh  = 4'b1000,
        op_wrl  = 4'b1001,
        op_itof = 4'b1010,
        op_ftoi = 4'b1011
    } alu_op_e;

    // Execution path picked by decode
    typedef enum logic [1:0] {
        single_cycle = 2'd0,
        muldiv       = 2'd1,
        conv         = 2'd2
    } alu_class_e;

    // IEEE single fields
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } alu_fp_t;

    typedef union packed {
        logic signed [31:0] as_int;
        alu_fp_t            as_fp;
    } alu_word_u;

    typedef struct packed {
        logic zero;
        logic error;
    } alu_flag_t;

endpackage

`default_nettype wire

// File: alu_if.sv
// Operation and result handshake interfaces between the ALU stages
`timescale 1ns/10ps
`default_nettype none
`include "alu_config.svh"

//////////////////////////////
// Decode to execute
//////////////////////////////
interface alu_op_if import alu_pkg::*; ();
    logic                   valid;
    alu_op_e                op;
    alu_class_e             cls;
    logic [`ALU_DATA_W-1:0] a;
    logic [`ALU_DATA_W-1:0] b;
    logic [`ALU_TAG_W-1:0]  tag;
    logic                   ready;

    modport source (output valid, op, cls, a, b, tag, input ready);
    modport sink   (input valid, op, cls, a, b, tag, output ready);
endinterface

//////////////////////////////
// Execute to result
//////////////////////////////
interface alu_res_if import alu_pkg::*; ();
    logic                   valid;
    logic [`ALU_DATA_W-1:0] data;
    alu_flag_t              flag;
    logic [`ALU_TAG_W-1:0]  tag;
    logic                   ready;

    modport source (output valid, data, flag, tag, input ready);
    modport sink   (input valid, data, flag, tag, output ready);
endinterface

`default_nettype wire

// File: alu_decode.sv
// Credit-fed input queue, path classification and dispatch to execute
`timescale 1ns/10ps
`default_nettype none
`include "alu_config.svh"

module alu_decode import alu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  alu_op_e                in_op,
    input  logic [`ALU_DATA_W-1:0] in_a,
    input  logic [`ALU_DATA_W-1:0] in_b,
    input  logic [`ALU_TAG_W-1:0]  in_tag,
    output logic                   in_credit,
    alu_op_if.source               op
);

    localparam int DEPTH = `ALU_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    alu_op_e                op_mem  [DEPTH];
    logic [`ALU_DATA_W-1:0] a_mem   [DEPTH];
    logic [`ALU_DATA_W-1:0] b_mem   [DEPTH];
    logic [`ALU_TAG_W-1:0]  tag_mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         count;
    logic                   pop;
    alu_op_e                head_op;

    assign head_op  = op_mem[rd_ptr];
    assign op.valid = (count != '0);
    assign op.op    = head_op;
    assign op.a     = a_mem[rd_ptr];
    assign op.b     = b_mem[rd_ptr];
    assign op.tag   = tag_mem[rd_ptr];
    assign pop      = op.valid && op.ready;

    // Path select, bit 2 is a don't-care on special ops
    always_comb begin
        if (head_op[3]) begin
            op.cls = head_op[1] ? conv : single_cycle;
        end else begin
            op.cls = head_op[2] ? single_cycle : muldiv;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count     <= count + {{PTR_W{1'b0}}, in_valid} - {{PTR_W{1'b0}}, pop};
            // Slot freed, hand the credit back
            in_credit <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_mem[wr_ptr]  <= in_op;
            a_mem[wr_ptr]   <= in_a;
            b_mem[wr_ptr]   <= in_b;
            tag_mem[wr_ptr] <= in_tag;
        end
    end

    // Upstream must hold a credit, so the queue is never full on a push
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> (count != (PTR_W + 1)'(DEPTH)));

endmodule

`default_nettype wire

// File: alu_muldiv.sv
// Signed add and sub, iterative shift-add multiply and restoring divide
`timescale 1ns/10ps
`default_nettype none

module alu_muldiv import alu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  alu_op_e     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        done,
    output logic [31:0] data,
    output alu_flag_t   flag
);

    logic        busy;
    logic [4:0]  cnt;
    logic        is_div;
    logic        neg;
    logic        div_zero;
    logic [63:0] acc;
    logic [63:0] mcand;
    logic [31:0] mplier;
    logic [63:0] acc_next;
    logic [63:0] shifted;
    logic        last;
    logic        is_addsub;
    logic [31:0] sum;
    logic        b_sign_eff;
    logic [31:0] a_mag;
    logic [31:0] b_mag;

    assign is_addsub  = (op == op_add) || (op == op_sub);
    assign sum        = (op == op_sub) ? a - b : a + b;
    assign b_sign_eff = b[31] ^ (op == op_sub);
    assign a_mag      = a[31] ? -a : a;
    assign b_mag      = b[31] ? -b : b;
    assign last       = busy && (cnt == 5'd31);
    assign done       = (start && is_addsub) || last;

    //////////////////////////////
    // One iteration step
    //////////////////////////////
    always_comb begin
        shifted  = {acc[62:0], 1'b0};
        acc_next = acc;
        if (is_div) begin
            // Remainder in the upper half, quotient bits enter at bit 0
            acc_next = shifted;
            if (shifted[63:32] >= mplier) begin
                acc_next[63:32] = shifted[63:32] - mplier;
                acc_next[0]     = 1'b1;
            end
        end else if (mplier[0]) begin
            // Bit 31 of the multiplier carries negative weight
            acc_next = (cnt == 5'd31) ? acc - mcand : acc + mcand;
        end
    end

    always_comb begin
        data       = acc_next[31:0];
        flag.error = acc_next[63:32] != {32{acc_next[31]}};
        if (start && is_addsub) begin
            data       = sum;
            flag.error = (a[31] == b_sign_eff) && (sum[31] != a[31]);
        end else if (is_div) begin
            data       = div_zero ? '1 : (neg ? -acc_next[31:0] : acc_next[31:0]);
            flag.error = div_zero;
        end
        flag.zero = (data == '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start && !is_addsub) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            busy <= !last;
            cnt  <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !is_addsub) begin
            is_div   <= (op == op_div);
            neg      <= a[31] ^ b[31];
            div_zero <= (b == '0);
            mcand    <= {{32{a[31]}}, a};
            mplier   <= (op == op_div) ? b_mag : b;
            acc      <= (op == op_div) ? {32'b0, a_mag} : '0;
        end else if (busy) begin
            acc   <= acc_next;
            mcand <= mcand << 1;
            if (!is_div) begin
                mplier <= mplier >> 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: alu_fpconv.sv
// Iterative integer to float and float to integer conversion, truncating
`timescale 1ns/10ps
`default_nettype none

module alu_fpconv import alu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      to_float,
    input  alu_word_u a,
    output logic      done,
    output alu_word_u data,
    output alu_flag_t flag
);

    logic        busy;
    logic        mode_itof;
    logic        sign;
    logic        err;
    logic [31:0] mag;
    logic [7:0]  cnt;
    logic [7:0]  exp_in;
    logic        min_int;

    assign exp_in  = a.as_fp.exponent;
    // -2^31 is the one value with exponent 158 that still fits
    assign min_int = a.as_fp.sign && (exp_in == 8'd158) && (a.as_fp.mantissa == '0);

    // itof stops once normalized, ftoi once the exponent shift is used up
    assign done = busy && (mode_itof ? (mag[31] || (mag == '0)) : (cnt == '0));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mode_itof <= to_float;
            // Sign sits in bit 31 for both views
            sign      <= a.as_fp.sign;
            err       <= 1'b0;
            cnt       <= '0;
            if (to_float) begin
                mag <= a.as_fp.sign ? -a.as_int : a.as_int;
            end else if (exp_in < 8'd127) begin
                mag <= '0;
            end else if (exp_in >= 8'd158) begin
                // Out of range, infinity or NaN saturate by sign
                mag <= a.as_fp.sign ? 32'h8000_0000 : 32'h7fff_ffff;
                err <= !min_int;
            end else begin
                mag <= {1'b1, a.as_fp.mantissa, 8'h00};
                cnt <= 8'd158 - exp_in;
            end
        end else if (busy && !done) begin
            if (mode_itof) begin
                mag <= mag << 1;
                cnt <= cnt + 1'b1;
            end else begin
                mag <= mag >> 1;
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_comb begin
        if (mode_itof) begin
            data.as_fp.sign     = sign;
            data.as_fp.exponent = 8'd158 - cnt;
            data.as_fp.mantissa = mag[30:8];
            if (mag == '0) begin
                data = '0;
            end
            flag.error = 1'b0;
        end else begin
            data.as_int = sign ? -mag : mag;
            flag.error  = err;
        end
        flag.zero = (data.as_int == '0);
    end

endmodule

`default_nettype wire

// File: alu_execute.sv
// Execute stage routing one operation to a unit and holding its result
`timescale 1ns/10ps
`default_nettype none

module alu_execute import alu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    alu_op_if.sink     op,
    alu_res_if.source  res
);

    logic        take;
    logic        sc_take;
    logic [31:0] sc_data;
    logic        md_start;
    logic        md_done;
    logic        md_active;
    logic [31:0] md_data;
    alu_flag_t   md_flag;
    logic        fc_start;
    logic        fc_done;
    logic        fc_active;
    alu_word_u   fc_data;
    alu_flag_t   fc_flag;

    // One operation in flight until its result leaves
    assign op.ready = !res.valid && !md_active && !fc_active;
    assign take     = op.valid && op.ready;
    assign sc_take  = take && (op.cls == single_cycle);
    assign md_start = take && (op.cls == muldiv);
    assign fc_start = take && (op.cls == conv);

    // Logic and half-word writes
    always_comb begin
        case ({op.op[3], op.op[1:0]})
            3'b000:  sc_data = ~op.a;
            3'b001:  sc_data = op.a & op.b;
            3'b010:  sc_data = op.a | op.b;
            3'b011:  sc_data = op.a ^ op.b;
            3'b100:  sc_data = {op.b[15:0], op.a[15:0]};
            default: sc_data = {op.a[31:16], op.b[15:0]};
        endcase
    end

    alu_muldiv i_alu_muldiv (
        .clk   (clk),
        .rst_n (rst_n),
        .start (md_start),
        .op    (op.op),
        .a     (op.a),
        .b     (op.b),
        .done  (md_done),
        .data  (md_data),
        .flag  (md_flag)
    );

    alu_fpconv i_alu_fpconv (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (fc_start),
        .to_float (~op.op[0]),
        .a        (op.a),
        .done     (fc_done),
        .data     (fc_data),
        .flag     (fc_flag)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
            md_active <= 1'b0;
            fc_active <= 1'b0;
        end else begin
            md_active <= (md_active || md_start) && !md_done;
            fc_active <= (fc_active || fc_start) && !fc_done;
            if (res.valid && res.ready) begin
                res.valid <= 1'b0;
            end else if (sc_take || md_done || fc_done) begin
                res.valid <= 1'b1;
            end
        end
    end

    // Result payload, held until the result stage takes it
    always_ff @(posedge clk) begin
        if (take) begin
            res.tag <= op.tag;
        end
        if (sc_take) begin
            res.data       <= sc_data;
            res.flag.zero  <= (sc_data == '0);
            res.flag.error <= 1'b0;
        end else if (md_done) begin
            res.data <= md_data;
            res.flag <= md_flag;
        end else if (fc_done) begin
            res.data <= fc_data;
            res.flag <= fc_flag;
        end
    end

    a_md_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        md_done |-> (md_active || md_start));
    a_fc_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        fc_done |-> fc_active);

endmodule

`default_nettype wire

// File: alu_result.sv
// In-order result buffer with downstream credit counter
`timescale 1ns/10ps
`default_nettype none
`include "alu_config.svh"

module alu_result import alu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    alu_res_if.sink                res,
    output logic                   res_valid,
    output logic [`ALU_DATA_W-1:0] res_data,
    output logic [1:0]             res_flag,
    output logic [`ALU_TAG_W-1:0]  res_tag,
    input  logic                   res_credit
);

    localparam int DEPTH  = `ALU_RESULT_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CRED_W = 8;

    logic [`ALU_DATA_W-1:0] data_mem [DEPTH];
    alu_flag_t              flag_mem [DEPTH];
    logic [`ALU_TAG_W-1:0]  tag_mem  [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         count;
    logic [CRED_W-1:0]      credits;
    logic                   push;

    assign res.ready = (count != (PTR_W + 1)'(DEPTH));
    assign push      = res.valid && res.ready;

    // Head goes out whenever downstream has granted a slot
    assign res_valid = (count != '0) && (credits != '0);
    assign res_data  = data_mem[rd_ptr];
    assign res_flag  = flag_mem[rd_ptr];
    assign res_tag   = tag_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (res_valid) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count   <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, res_valid};
            credits <= credits + {{(CRED_W - 1){1'b0}}, res_credit}
                     - {{(CRED_W - 1){1'b0}}, res_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= res.data;
            flag_mem[wr_ptr] <= res.flag;
            tag_mem[wr_ptr]  <= res.tag;
        end
    end

    // Grants beyond the counter range would be lost
    a_credit_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        (res_credit && !res_valid) |-> (credits != '1));

endmodule

`default_nettype wire

// File: alu_top.sv
// ALU execution unit top level with decode, execute and result stages
`timescale 1ns/10ps
`default_nettype none
`include "alu_config.svh"

module alu_top import alu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  alu_op_e                in_op,
    input  logic [`ALU_DATA_W-1:0] in_a,
    input  logic [`ALU_DATA_W-1:0] in_b,
    input  logic [`ALU_TAG_W-1:0]  in_tag,
    output logic                   in_credit,
    output logic                   res_valid,
    output logic [`ALU_DATA_W-1:0] res_data,
    output logic [1:0]             res_flag,
    output logic [`ALU_TAG_W-1:0]  res_tag,
    input  logic                   res_credit
);

    alu_op_if  op_bus ();
    alu_res_if res_bus ();

    alu_decode i_alu_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_tag    (in_tag),
        .in_credit (in_credit),
        .op        (op_bus.source)
    );

    alu_execute i_alu_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (op_bus.sink),
        .res   (res_bus.source)
    );

    alu_result i_alu_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .res        (res_bus.sink),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_flag   (res_flag),
        .res_tag    (res_tag),
        .res_credit (res_credit)
    );

endmodule

`default_nettype wire

// File: tb_alu_top.sv
// Testbench for alu_top with reference model, credit tracking and checks
`timescale 1ns/10ps
`default_nettype none
`include "alu_config.svh"

module tb_alu_top import alu_pkg::*; ();

    localparam int N_OPS = 100;
    localparam int LIMIT = N_OPS * 40 + 2000;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    alu_op_e                in_op;
    logic [`ALU_DATA_W-1:0] in_a;
    logic [`ALU_DATA_W-1:0] in_b;
    logic [`ALU_TAG_W-1:0]  in_tag;
    logic                   in_credit;
    logic                   res_valid;
    logic [`ALU_DATA_W-1:0] res_data;
    logic [1:0]             res_flag;
    logic [`ALU_TAG_W-1:0]  res_tag;
    logic                   res_credit;

    logic [31:0] lcg_state = 32'ha10f;
    logic [37:0] exp_q [$];
    int          up_credits = `ALU_QUEUE_DEPTH;
    int          out_credits = 0;
    int          credit_pulses = 0;
    int          issued = 0;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          grant_mode = 0;

    alu_top i_alu_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////
    // Returns {zero, error, data}
    function automatic logic [33:0] model(input logic [3:0] code, input logic [31:0] a,
                                          input logic [31:0] b);
        logic [31:0] r;
        logic        err;
        logic [31:0] mag;
        longint      wide;
        int          msb;
        logic [7:0]  e;
        r   = '0;
        err = 1'b0;
        msb = 0;
        e   = a[30:23];
        if (code[3]) begin
            case (code[1:0])
                2'b00: r = {b[15:0], a[15:0]};
                2'b01: r = {a[31:16], b[15:0]};
                2'b10: begin
                    if (a != '0) begin
                        mag = a[31] ? -a : a;
                        for (int i = 0; i < 32; i++) begin
                            if (mag[i]) msb = i;
                        end
                        mag = mag << (31 - msb);
                        r   = {a[31], 8'(127 + msb), mag[30:8]};
                    end
                end
                default: begin
                    if (e >= 8'd158) begin
                        r   = a[31] ? 32'h8000_0000 : 32'h7fff_ffff;
                        err = (a != 32'hcf00_0000);
                    end else if (e >= 8'd127) begin
                        // Significand as an integer, scaled by 2^(e - 150)
                        mag = {8'h00, 1'b1, a[22:0]};
                        if (e >= 8'd150) begin
                            mag = mag << (e - 8'd150);
                        end else begin
                            mag = mag >> (8'd150 - e);
                        end
                        r   = a[31] ? -mag : mag;
                    end
                end
            endcase
        end else begin
            case (code[2:0])
                3'd0, 3'd1, 3'd2: begin
                    if (code[1:0] == 2'd0) wide = longint'($signed(a)) + longint'($signed(b));
                    else if (code[1:0] == 2'd1) wide = longint'($signed(a)) - longint'($signed(b));
                    else wide = longint'($signed(a)) * longint'($signed(b));
                    r   = wide[31:0];
                    err = (wide != longint'($signed(r)));
                end
                3'd3: begin
                    if (b == '0) begin
                        r   = '1;
                        err = 1'b1;
                    end else begin
                        wide = longint'($signed(a)) / longint'($signed(b));
                        r    = wide[31:0];
                    end
                end
                3'd4: r = ~a;
                3'd5: r = a & b;
                3'd6: r = a | b;
                default: r = a ^ b;
            endcase
        end
        return {(r == '0), err, r};
    endfunction

    // Waits for an upstream credit, then issues one operation
    task automatic issue(input logic [3:0] code, input logic [31:0] a, input logic [31:0] b);
        logic [`ALU_TAG_W-1:0] tag;
        tag = issued[`ALU_TAG_W-1:0];
        while (up_credits == 0) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_op    = alu_op_e'(code);
        in_a     = a;
        in_b     = b;
        in_tag   = tag;
        exp_q.push_back({tag, model(code, a, b)});
        up_credits--;
        issued++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input string name);
        drain();
        $display("test %s done, %0d checks, %0d errors so far", name, checks, errors);
    endtask

    // Downstream slot grants
    always @(posedge clk) begin
        int   mode;
        logic coin;
        mode = grant_mode;
        coin = (mode != 1) || (lcg_next() > 32'h8000_0000);
        #1;
        res_credit = (mode != 0) && coin && (out_credits < 16);
    end

    //////////////////////////////
    // Output monitor
    //////////////////////////////
    always @(posedge clk) begin
        logic [37:0] head;
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout after %0d cycles with %0d results outstanding", cycles,
                     exp_q.size());
            $display("Some tests failed");
            $finish;
        end else if (!rst_n) begin
            // Reset values are in place from the second edge on
            if (cycles > 1) begin
                assert (!res_valid && !in_credit) else begin
                    $display("Output active during reset");
                    errors++;
                end
            end
        end else begin
            if (in_credit) begin
                up_credits++;
                credit_pulses++;
            end
            if (res_credit) out_credits++;
            if (res_valid) begin
                out_credits--;
                checks++;
                if (exp_q.size() == 0) begin
                    $display("Result appeared with no operation outstanding");
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    assert (res_tag == head[37:34]) else begin
                        $display("MISMATCH res_tag expected %h got %h", head[37:34], res_tag);
                        errors++;
                    end
                    assert (res_flag == head[33:32]) else begin
                        $display("MISMATCH res_flag expected %h got %h", head[33:32], res_flag);
                        errors++;
                    end
                    assert (res_data == head[31:0]) else begin
                        $display("MISMATCH res_data expected %h got %h", head[31:0], res_data);
                        errors++;
                    end
                end
            end
        end
    end

    a_res_credit: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> out_credits > 0)
        else begin
            $display("Result sent without a downstream credit");
            errors++;
        end

    initial begin
        logic [3:0] code;
        int         seen;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_op      = op_add;
        in_a       = '0;
        in_b       = '0;
        in_tag     = '0;
        res_credit = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Slots granted while idle, so a stray result would show
        grant_mode = 2;
        repeat (20) @(posedge clk);
        #1;
        $display("test reset_idle done, %0d errors so far", errors);

        // Logic ops, then write high and low and their 1100 and 1101 aliases
        issue(4'b0101, 32'hf0f0_0000, 32'h0f0f_ffff);
        issue(4'b0100, 32'hffff_ffff, 32'h0);
        for (int i = 0; i < 8; i++) begin
            code = (i < 4) ? 4'(4 + i) : 4'(8 + (i - 4) % 2 + 4 * ((i - 4) / 2));
            issue(code, lcg_next(), lcg_next());
        end
        finish_test("logic_write");

        issue(4'b0000, 32'h7fff_ffff, 32'h1);
        issue(4'b0001, 32'h8000_0000, 32'h1);
        issue(4'b0010, 32'h0001_0000, 32'h0001_0000);
        issue(4'b0010, 32'hffff_fffd, 32'hffff_fffd);
        issue(4'b0011, 32'hffff_fff9, 32'h2);
        issue(4'b0011, 32'h5, 32'h0);
        issue(4'b0011, 32'h8000_0000, 32'hffff_ffff);
        issue(4'b0000, 32'h5, 32'hffff_fffb);
        for (int i = 0; i < 12; i++) begin
            issue(4'(i % 4), lcg_next(), lcg_next() >> (i % 3) * 8);
        end
        finish_test("arith");

        issue(4'b1010, 32'h0, 32'h0);
        issue(4'b1010, 32'hffff_ffff, 32'h0);
        issue(4'b1010, 32'h0000_0400, 32'h0);
        issue(4'b1010, 32'h7fff_ffff, 32'h0);
        issue(4'b1110, 32'h8000_0000, 32'h0);
        issue(4'b1010, lcg_next(), 32'h0);
        issue(4'b1011, 32'h3f80_0000, 32'h0);
        issue(4'b1011, 32'hbfc0_0000, 32'h0);
        issue(4'b1011, 32'h4f00_0000, 32'h0);
        issue(4'b1011, 32'hcf00_0000, 32'h0);
        issue(4'b1111, 32'h7fc0_0000, 32'h0);
        issue(4'b1011, 32'h3e80_0000, 32'h0);
        issue(4'b1011, 32'hd000_0000, 32'h0);
        issue(4'b1011, 32'h4b7f_ffff, 32'h0);
        finish_test("convert");

        // Spend the downstream credits still held, then withhold new ones
        grant_mode = 0;
        @(posedge clk);
        #1;
        while (out_credits > exp_q.size()) begin
            issue(4'b0110, lcg_next(), lcg_next());
        end
        while (out_credits != 0) begin
            @(posedge clk);
            #1;
        end
        // Fill the result buffer, execute and the decode queue
        seen = checks;
        for (int i = 0; i < `ALU_QUEUE_DEPTH + `ALU_RESULT_DEPTH + 1; i++) begin
            issue(4'b0110, lcg_next(), lcg_next());
        end
        repeat (100) @(posedge clk);
        #1;
        assert (checks == seen) else begin
            $display("Result appeared while downstream credits were withheld");
            errors++;
        end
        grant_mode = 1;
        for (int i = 0; i < 30; i++) begin
            issue(4'(lcg_next() % 12), lcg_next(), lcg_next());
        end
        finish_test("backpressure");

        repeat (5) @(posedge clk);
        #1;
        assert (credit_pulses == issued && up_credits == `ALU_QUEUE_DEPTH) else begin
            $display("Upstream credits lost, %0d returned for %0d issued", credit_pulses,
                     issued);
            errors++;
        end
        $display("test credits done, %0d errors so far", errors);

        $display("%0d operations, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
alu_pkg.sv
alu_if.sv
alu_decode.sv
alu_muldiv.sv
alu_fpconv.sv
alu_execute.sv
alu_result.sv
alu_top.sv
tb_alu_top.sv

// File: run.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_alu_top -f list.f -o sim_alu \
    > build.log 2>&1 \
    && ./obj_dir/sim_alu > sim.log 2>&1 \
    || echo "Build or simulation ended abnormally"
grep -q "All tests passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
